//--- dv/tl_xbar_checker.sv
// ----------------------------------------------------------------------
// Watches the crossbar ports at the falling edge. One open request per
// host at a time, registered through expect_row before it is driven.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "tl_xbar_defs.svh"

module tl_xbar_checker (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        host_a_valid_i  [`TL_NUM_HOSTS-1:0],
  input logic                        host_a_ready_o  [`TL_NUM_HOSTS-1:0],
  input logic                        host_d_valid_o  [`TL_NUM_HOSTS-1:0],
  input logic                        host_d_ready_i  [`TL_NUM_HOSTS-1:0],
  input tl_pkg::tl_d_op_e            host_d_opcode_o [`TL_NUM_HOSTS-1:0],
  input logic [`TL_SIZE_WIDTH-1:0]   host_d_size_o   [`TL_NUM_HOSTS-1:0],
  input logic [`TL_SOURCE_WIDTH-1:0] host_d_source_o [`TL_NUM_HOSTS-1:0],
  input logic                        host_d_denied_o [`TL_NUM_HOSTS-1:0],
  input logic [`TL_DATA_WIDTH-1:0]   host_d_data_o   [`TL_NUM_HOSTS-1:0],
  input logic                        dev_a_valid_o   [`TL_NUM_DEVICES-1:0],
  input tl_pkg::tl_a_op_e            dev_a_opcode_o  [`TL_NUM_DEVICES-1:0],
  input logic [`TL_SIZE_WIDTH-1:0]   dev_a_size_o    [`TL_NUM_DEVICES-1:0],
  input logic [`TL_SOURCE_WIDTH-1:0] dev_a_source_o  [`TL_NUM_DEVICES-1:0],
  input logic [`TL_ADDR_WIDTH-1:0]   dev_a_address_o [`TL_NUM_DEVICES-1:0],
  input logic [`TL_DATA_WIDTH/8-1:0] dev_a_mask_o    [`TL_NUM_DEVICES-1:0],
  input logic [`TL_DATA_WIDTH-1:0]   dev_a_data_o    [`TL_NUM_DEVICES-1:0]
);
  import tl_pkg::*;

  int errors = 0;
  int rows_done = 0;
  int rows_pass = 0;
  int rows_fail = 0;
  int cyc = 0;
  logic reset_checked = 1'b0;

  // Open request per host
  logic        open_q   [3] = '{default: 1'b0};
  logic        seen_q   [3] = '{default: 1'b0};
  logic        solo_q   [3];
  logic        held_q   [3] = '{default: 1'b0};
  logic [31:0] held_data[3];
  int          row_q    [3];
  int          dev_q    [3];
  int          a_cyc    [3];
  int          err_base [3];
  tl_a_op_e    op_q     [3];
  logic [2:0]  src_q    [3];
  logic [1:0]  size_q   [3];
  logic [3:0]  mask_q   [3];
  logic [31:0] addr_q   [3];
  logic [31:0] data_q   [3];
  logic [31:0] rdata_q  [3];
  tl_d_op_e    dop_q    [3];

  task automatic expect_row(int row, int host, int dev, tl_a_op_e op, logic [2:0] src,
                            logic [1:0] size, logic [3:0] mask, logic [31:0] addr,
                            logic [31:0] data, tl_d_op_e dop, logic [31:0] rdata,
                            logic solo);
    open_q[host]   = 1'b1;
    seen_q[host]   = 1'b0;
    solo_q[host]   = solo;
    row_q[host]    = row;
    dev_q[host]    = dev;
    op_q[host]     = op;
    src_q[host]    = src;
    size_q[host]   = size;
    mask_q[host]   = mask;
    addr_q[host]   = addr;
    data_q[host]   = data;
    dop_q[host]    = dop;
    rdata_q[host]  = rdata;
    a_cyc[host]    = -10;
    err_base[host] = errors;
  endtask

  // Host whose open request carries this source, -1 if none
  function automatic int open_host(logic [2:0] src);
    for (int k = 0; k < 3; k++) begin
      if (open_q[k] && src_q[k] == src) return k;
    end
    return -1;
  endfunction

  task automatic report_value(string name, logic [31:0] exp, logic [31:0] got);
    errors++;
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
  endtask

  task automatic report_problem(string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  always @(negedge clk_i) begin
    int h;
    if (reset_i) begin
      cyc = 0;
    end else begin
      cyc++;
      if (!reset_checked) begin
        reset_checked = 1'b1;
        for (int k = 0; k < 3; k++) begin
          if (host_d_valid_o[k])
            report_problem($sformatf("host_d_valid_o[%0d] high after reset", k));
          if (dev_a_valid_o[k])
            report_problem($sformatf("dev_a_valid_o[%0d] high after reset", k));
        end
        $display("Reset check done");
      end
      for (int k = 0; k < 3; k++) begin
        if (host_a_valid_i[k] && host_a_ready_o[k]) a_cyc[k] = cyc;
      end
      for (int d = 0; d < 3; d++) begin
        if (dev_a_valid_o[d]) begin
          h = open_host(dev_a_source_o[d]);
          if (h < 0) begin
            report_problem($sformatf("device %0d got source %0d with no open request",
                                     d, dev_a_source_o[d]));
          end else if (!seen_q[h]) begin
            seen_q[h] = 1'b1;
            if (d != dev_q[h])
              report_problem($sformatf("row %0d went to device %0d instead of device %0d",
                                       row_q[h], d, dev_q[h]));
            if (dev_a_opcode_o[d] != op_q[h])
              report_value($sformatf("dev_a_opcode_o[%0d]", d),
                           32'(op_q[h]), 32'(dev_a_opcode_o[d]));
            if (dev_a_size_o[d] != size_q[h])
              report_value($sformatf("dev_a_size_o[%0d]", d),
                           32'(size_q[h]), 32'(dev_a_size_o[d]));
            if (dev_a_mask_o[d] != mask_q[h])
              report_value($sformatf("dev_a_mask_o[%0d]", d),
                           32'(mask_q[h]), 32'(dev_a_mask_o[d]));
            if (dev_a_address_o[d] != addr_q[h])
              report_value($sformatf("dev_a_address_o[%0d]", d), addr_q[h], dev_a_address_o[d]);
            if (dev_a_data_o[d] != data_q[h])
              report_value($sformatf("dev_a_data_o[%0d]", d), data_q[h], dev_a_data_o[d]);
            if (solo_q[h] && cyc != a_cyc[h] + 1)
              report_problem($sformatf("row %0d reached device %0d late", row_q[h], d));
          end
        end
      end
      for (int k = 0; k < 3; k++) begin
        if (held_q[k] && !host_d_valid_o[k]) begin
          report_problem($sformatf("host %0d response withdrawn before transfer", k));
        end else if (held_q[k] && host_d_data_o[k] != held_data[k]) begin
          report_value($sformatf("host_d_data_o[%0d]", k), held_data[k], host_d_data_o[k]);
        end
        held_q[k] = 1'b0;
        if (host_d_valid_o[k] && !host_d_ready_i[k]) begin
          held_q[k]    = 1'b1;
          held_data[k] = host_d_data_o[k];
        end else if (host_d_valid_o[k]) begin
          if (!open_q[k]) begin
            report_problem($sformatf("extra response at host %0d", k));
          end else begin
            if (host_d_source_o[k] != src_q[k])
              report_value($sformatf("host_d_source_o[%0d]", k),
                           32'(src_q[k]), 32'(host_d_source_o[k]));
            if (host_d_opcode_o[k] != dop_q[k])
              report_value($sformatf("host_d_opcode_o[%0d]", k),
                           32'(dop_q[k]), 32'(host_d_opcode_o[k]));
            if (host_d_size_o[k] != size_q[k])
              report_value($sformatf("host_d_size_o[%0d]", k),
                           32'(size_q[k]), 32'(host_d_size_o[k]));
            // Device models never deny
            if (host_d_denied_o[k] != 1'b0)
              report_value($sformatf("host_d_denied_o[%0d]", k),
                           32'h0, 32'(host_d_denied_o[k]));
            if (host_d_data_o[k] != rdata_q[k])
              report_value($sformatf("host_d_data_o[%0d]", k), rdata_q[k], host_d_data_o[k]);
            if (!seen_q[k])
              report_problem($sformatf("row %0d never seen at a device", row_q[k]));
            open_q[k] = 1'b0;
            rows_done++;
            if (errors == err_base[k]) begin
              rows_pass++;
              $display("Row %0d host %0d: ok", row_q[k], k);
            end else begin
              rows_fail++;
              $display("Row %0d host %0d: failed", row_q[k], k);
            end
          end
        end
      end
    end
  end

endmodule

//--- dv/tl_xbar_tb.sv
// ----------------------------------------------------------------------
// Crossbar testbench. Hosts in one group must be distinct, and device
// models keep one response in flight each, keyed by full address.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "tl_xbar_defs.svh"

module tl_xbar_tb;
  import tl_pkg::*;

  localparam int NROWS = 18;
  localparam int LIMIT = NROWS * 40;

  // Every request is a full word
  localparam logic [1:0] A_SIZE = 2'd2;
  localparam logic [3:0] A_MASK = 4'hf;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  int   cycles = 0;

  logic                        host_a_valid_i   [`TL_NUM_HOSTS-1:0];
  logic                        host_a_ready_o   [`TL_NUM_HOSTS-1:0];
  tl_a_op_e                    host_a_opcode_i  [`TL_NUM_HOSTS-1:0];
  logic [`TL_SIZE_WIDTH-1:0]   host_a_size_i    [`TL_NUM_HOSTS-1:0];
  logic [`TL_SOURCE_WIDTH-1:0] host_a_source_i  [`TL_NUM_HOSTS-1:0];
  logic [`TL_ADDR_WIDTH-1:0]   host_a_address_i [`TL_NUM_HOSTS-1:0];
  logic [`TL_DATA_WIDTH/8-1:0] host_a_mask_i    [`TL_NUM_HOSTS-1:0];
  logic [`TL_DATA_WIDTH-1:0]   host_a_data_i    [`TL_NUM_HOSTS-1:0];
  logic                        host_d_valid_o   [`TL_NUM_HOSTS-1:0];
  logic                        host_d_ready_i   [`TL_NUM_HOSTS-1:0] = '{default: 1'b0};
  tl_d_op_e                    host_d_opcode_o  [`TL_NUM_HOSTS-1:0];
  logic [`TL_SIZE_WIDTH-1:0]   host_d_size_o    [`TL_NUM_HOSTS-1:0];
  logic [`TL_SOURCE_WIDTH-1:0] host_d_source_o  [`TL_NUM_HOSTS-1:0];
  logic                        host_d_denied_o  [`TL_NUM_HOSTS-1:0];
  logic [`TL_DATA_WIDTH-1:0]   host_d_data_o    [`TL_NUM_HOSTS-1:0];

  logic                        dev_a_valid_o    [`TL_NUM_DEVICES-1:0];
  logic                        dev_a_ready_i    [`TL_NUM_DEVICES-1:0] = '{default: 1'b0};
  tl_a_op_e                    dev_a_opcode_o   [`TL_NUM_DEVICES-1:0];
  logic [`TL_SIZE_WIDTH-1:0]   dev_a_size_o     [`TL_NUM_DEVICES-1:0];
  logic [`TL_SOURCE_WIDTH-1:0] dev_a_source_o   [`TL_NUM_DEVICES-1:0];
  logic [`TL_ADDR_WIDTH-1:0]   dev_a_address_o  [`TL_NUM_DEVICES-1:0];
  logic [`TL_DATA_WIDTH/8-1:0] dev_a_mask_o     [`TL_NUM_DEVICES-1:0];
  logic [`TL_DATA_WIDTH-1:0]   dev_a_data_o     [`TL_NUM_DEVICES-1:0];
  logic                        dev_d_valid_i    [`TL_NUM_DEVICES-1:0] = '{default: 1'b0};
  logic                        dev_d_ready_o    [`TL_NUM_DEVICES-1:0];
  tl_d_op_e                    dev_d_opcode_i   [`TL_NUM_DEVICES-1:0] = '{default: AccessAck};
  logic [`TL_SIZE_WIDTH-1:0]   dev_d_size_i     [`TL_NUM_DEVICES-1:0] = '{default: '0};
  logic [`TL_SOURCE_WIDTH-1:0] dev_d_source_i   [`TL_NUM_DEVICES-1:0] = '{default: '0};
  logic                        dev_d_denied_i   [`TL_NUM_DEVICES-1:0] = '{default: 1'b0};
  logic [`TL_DATA_WIDTH-1:0]   dev_d_data_i     [`TL_NUM_DEVICES-1:0] = '{default: '0};

  // Stimulus table, rows sharing a group id are issued together
  int          row_grp   [NROWS];
  int          row_host  [NROWS];
  tl_a_op_e    row_op    [NROWS];
  logic [31:0] row_addr  [NROWS];
  logic [31:0] row_data  [NROWS];
  int          row_dev   [NROWS];
  tl_d_op_e    row_dop   [NROWS];
  logic [31:0] row_rdata [NROWS];
  int          n_rows = 0;

  // Device word stores, key is {device, address}
  logic [31:0] store [logic [33:0]];

  tl_xbar DUT (.*);

  tl_xbar_checker u_chk (.*);

  initial begin
    forever #20 clk_i = ~clk_i;
  end

  task automatic add_row(int grp, int host, tl_a_op_e op, logic [31:0] addr,
                         logic [31:0] data, int dev, tl_d_op_e dop, logic [31:0] rdata);
    row_grp[n_rows]   = grp;
    row_host[n_rows]  = host;
    row_op[n_rows]    = op;
    row_addr[n_rows]  = addr;
    row_data[n_rows]  = data;
    row_dev[n_rows]   = dev;
    row_dop[n_rows]   = dop;
    row_rdata[n_rows] = rdata;
    n_rows++;
  endtask

  function automatic logic [2:0] host_source(int host, int row);
    logic [2:0] base;
    base = (host == 0) ? 3'd0 : (host == 1) ? 3'd4 : 3'd6;
    return base + 3'(row % 2);
  endfunction

  // Device models, one response in flight per device
  always @(posedge clk_i) begin
    logic        busy;
    logic [33:0] key;
    for (int d = 0; d < `TL_NUM_DEVICES; d++) begin
      if (reset_i) begin
        dev_d_valid_i[d] <= 1'b0;
        dev_a_ready_i[d] <= 1'b0;
      end else begin
        busy = dev_d_valid_i[d] && !dev_d_ready_o[d];
        key  = {2'(d), dev_a_address_o[d]};
        if (dev_a_valid_o[d] && dev_a_ready_i[d]) begin
          busy = 1'b1;
          dev_d_valid_i[d]  <= 1'b1;
          dev_d_source_i[d] <= dev_a_source_o[d];
          dev_d_size_i[d]   <= dev_a_size_o[d];
          if (dev_a_opcode_o[d] == Get) begin
            dev_d_opcode_i[d] <= AccessAckData;
            dev_d_data_i[d]   <= store.exists(key) ? store[key] : 32'h0;
          end else begin
            store[key]        = dev_a_data_o[d];
            dev_d_opcode_i[d] <= AccessAck;
            dev_d_data_i[d]   <= 32'h0;
          end
        end else if (dev_d_ready_o[d]) begin
          dev_d_valid_i[d] <= 1'b0;
        end
        dev_a_ready_i[d] <= !busy && ($urandom % 4 != 0);
      end
    end
    for (int h = 0; h < `TL_NUM_HOSTS; h++) begin
      host_d_ready_i[h] <= !reset_i && ($urandom % 3 != 0);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout: rows did not complete within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int i;
    int j;
    int open;
    int h;
    void'($urandom(32'h51b4_31b5));
    for (int k = 0; k < `TL_NUM_HOSTS; k++) begin
      host_a_valid_i[k]   = 1'b0;
      host_a_opcode_i[k]  = Get;
      host_a_size_i[k]    = A_SIZE;
      host_a_source_i[k]  = 3'd0;
      host_a_address_i[k] = 32'h0;
      host_a_mask_i[k]    = A_MASK;
      host_a_data_i[k]    = 32'h0;
    end
    // Solo rows: round trips on each device, unwritten word, unmapped nibble
    add_row(0, 0, PutFullData, 32'h0000_0010, 32'ha5a5_0001, 0, AccessAck, 32'h0);
    add_row(1, 0, Get,         32'h0000_0010, 32'h0,         0, AccessAckData, 32'ha5a5_0001);
    add_row(2, 1, PutFullData, 32'h1000_0020, 32'h1111_0002, 1, AccessAck, 32'h0);
    add_row(3, 1, Get,         32'h1000_0020, 32'h0,         1, AccessAckData, 32'h1111_0002);
    add_row(4, 2, PutFullData, 32'h2000_0030, 32'h2222_0003, 2, AccessAck, 32'h0);
    add_row(5, 2, Get,         32'h2000_0030, 32'h0,         2, AccessAckData, 32'h2222_0003);
    add_row(6, 0, Get,         32'h2000_0040, 32'h0,         2, AccessAckData, 32'h0);
    add_row(7, 1, PutFullData, 32'h7000_0010, 32'h7777_0004, 0, AccessAck, 32'h0);
    add_row(8, 2, Get,         32'h7000_0010, 32'h0,         0, AccessAckData, 32'h7777_0004);
    // All three hosts at once
    add_row(9, 0, PutFullData, 32'h1000_0050, 32'h5050_0005, 1, AccessAck, 32'h0);
    add_row(9, 1, PutFullData, 32'h2000_0060, 32'h6060_0006, 2, AccessAck, 32'h0);
    add_row(9, 2, PutFullData, 32'h0000_0070, 32'h7070_0007, 0, AccessAck, 32'h0);
    add_row(10, 0, Get, 32'h2000_0060, 32'h0, 2, AccessAckData, 32'h6060_0006);
    add_row(10, 1, Get, 32'h0000_0070, 32'h0, 0, AccessAckData, 32'h7070_0007);
    add_row(10, 2, Get, 32'h1000_0050, 32'h0, 1, AccessAckData, 32'h5050_0005);
    add_row(11, 0, Get, 32'h1000_0020, 32'h0, 1, AccessAckData, 32'h1111_0002);
    add_row(11, 1, Get, 32'h1000_0050, 32'h0, 1, AccessAckData, 32'h5050_0005);
    add_row(11, 2, Get, 32'h1000_0080, 32'h0, 1, AccessAckData, 32'h0);
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    i = 0;
    while (i < n_rows) begin
      j = i;
      while (j < n_rows && row_grp[j] == row_grp[i]) j++;
      @(posedge clk_i);
      for (int k = i; k < j; k++) begin
        h = row_host[k];
        u_chk.expect_row(k, h, row_dev[k], row_op[k], host_source(h, k), A_SIZE, A_MASK,
                         row_addr[k], row_data[k], row_dop[k], row_rdata[k], (j - i) == 1);
        host_a_valid_i[h]   <= 1'b1;
        host_a_opcode_i[h]  <= row_op[k];
        host_a_source_i[h]  <= host_source(h, k);
        host_a_address_i[h] <= row_addr[k];
        host_a_data_i[h]    <= row_data[k];
      end
      open = j - i;
      while (open > 0) begin
        @(posedge clk_i);
        for (int k = i; k < j; k++) begin
          h = row_host[k];
          if (host_a_valid_i[h] && host_a_ready_o[h]) begin
            host_a_valid_i[h] <= 1'b0;
            open--;
          end
        end
      end
      wait (u_chk.rows_done == j);
      i = j;
    end
    repeat (4) @(posedge clk_i);
    $display("Rows run %0d, passed %0d, failed %0d, errors %0d",
             n_rows, u_chk.rows_pass, u_chk.rows_fail, u_chk.errors);
    if (u_chk.errors == 0 && u_chk.rows_done == n_rows) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tl_xbar_tb \
  -o tl_xbar_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/tl_xbar_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  echo "Test passed"
  exit 0
fi
echo "Test failed, see sim.log"
exit 1

//--- src.f
+incdir+src
src/tl_pkg.sv
src/tl_if.sv
src/tl_reg_slice.sv
src/tl_socket_m1.sv
src/tl_socket_1n.sv
src/tl_xbar.sv
dv/tl_xbar_checker.sv
dv/tl_xbar_tb.sv

//--- src/tl_if.sv
// ----------------------------------------------------------------------
// One TL-UL link, A and D channels only. Carries no clock.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

interface tl_if;
  import tl_pkg::*;

  // Requests
  logic  a_valid;
  logic  a_ready;
  tl_a_t a;

  // Responses
  logic  d_valid;
  logic  d_ready;
  tl_d_t d;

  modport host (
    output a_valid, a, d_ready,
    input  a_ready, d_valid, d
  );

  modport device (
    input  a_valid, a, d_ready,
    output a_ready, d_valid, d
  );

endinterface

//--- src/tl_pkg.sv
// ----------------------------------------------------------------------
// TL-UL message types. Single beat only, no param or corrupt fields.
// ----------------------------------------------------------------------
`include "tl_xbar_defs.svh"

package tl_pkg;

  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Request beat
  typedef struct packed {
    tl_a_op_e                     opcode;
    logic [`TL_SIZE_WIDTH-1:0]    size;
    logic [`TL_SOURCE_WIDTH-1:0]  source;
    logic [`TL_ADDR_WIDTH-1:0]    address;
    logic [`TL_DATA_WIDTH/8-1:0]  mask;
    logic [`TL_DATA_WIDTH-1:0]    data;
  } tl_a_t;

  // Response beat
  typedef struct packed {
    tl_d_op_e                     opcode;
    logic [`TL_SIZE_WIDTH-1:0]    size;
    logic [`TL_SOURCE_WIDTH-1:0]  source;
    logic                         denied;
    logic [`TL_DATA_WIDTH-1:0]    data;
  } tl_d_t;

endpackage

//--- src/tl_reg_slice.sv
// ----------------------------------------------------------------------
// One-entry valid/ready register. Full throughput, one cycle latency.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tl_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;

  // Can take a new beat while the held one drains
  assign in_ready_o  = ~full_q | out_ready_i;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  // Stalled beat must not change under the consumer
  a_hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- src/tl_socket_1n.sv
// ----------------------------------------------------------------------
// One link to devices. Decode uses the top address nibble only and
// unmapped nibbles fall to device 0. Responses merge round robin.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "tl_xbar_defs.svh"

module tl_socket_1n (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            link_a_valid_i,
  output logic            link_a_ready_o,
  input  tl_pkg::tl_a_t   link_a_i,
  output logic            link_d_valid_o,
  input  logic            link_d_ready_i,
  output tl_pkg::tl_d_t   link_d_o,
  tl_if.host              dev_if [`TL_NUM_DEVICES-1:0]
);
  import tl_pkg::*;

  localparam int N    = `TL_NUM_DEVICES;
  localparam int IdxW = $clog2(N);

  logic [N-1:0]    dev_a_valid;
  logic [N-1:0]    dev_a_ready;
  logic [N-1:0]    rsp;
  tl_d_t           rsp_d [N-1:0];
  logic [IdxW-1:0] a_dev;
  logic [IdxW-1:0] last_q;
  logic [IdxW-1:0] arb_sel;
  logic [IdxW-1:0] sel;
  logic [IdxW-1:0] lock_sel_q;
  logic            lock_q;

  function automatic logic [IdxW-1:0] addr_dev(logic [`TL_ADDR_WIDTH-1:0] addr);
    logic [3:0] nib;
    nib = addr[`TL_ADDR_WIDTH-1 -: 4];
    if (nib == `TL_DEV1_BASE) return IdxW'(1);
    if (nib == `TL_DEV2_BASE) return IdxW'(2);
    return IdxW'(0);
  endfunction

  assign a_dev          = addr_dev(link_a_i.address);
  assign link_a_ready_o = dev_a_ready[a_dev];

  for (genvar i = 0; i < N; i++) begin : g_dev
    assign dev_a_valid[i]    = link_a_valid_i && (a_dev == IdxW'(i));
    assign dev_if[i].a_valid = dev_a_valid[i];
    assign dev_if[i].a       = link_a_i;
    assign dev_a_ready[i]    = dev_if[i].a_ready;
    assign rsp[i]            = dev_if[i].d_valid;
    assign rsp_d[i]          = dev_if[i].d;
    assign dev_if[i].d_ready = link_d_ready_i && rsp[i] && (sel == IdxW'(i));
  end

  // Round robin over responding devices
  always_comb begin
    int idx;
    arb_sel = last_q;
    for (int k = N; k >= 1; k--) begin
      idx = (int'(last_q) + k) % N;
      if (rsp[idx]) begin
        arb_sel = IdxW'(idx);
      end
    end
  end

  // Winner stays put while the D slice is full
  assign sel            = lock_q ? lock_sel_q : arb_sel;
  assign link_d_valid_o = rsp[sel];
  assign link_d_o       = rsp_d[sel];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      last_q <= IdxW'(N - 1);
    end else begin
      lock_q <= link_d_valid_o && !link_d_ready_i;
      if (link_d_valid_o && link_d_ready_i) begin
        last_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    lock_sel_q <= sel;
  end

  a_one_dev: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(dev_a_valid));

endmodule

//--- src/tl_socket_m1.sv
// ----------------------------------------------------------------------
// Hosts to one link. Grant is held while the link stalls a request.
// Responses route by source ID; host 0 owns every ID below host 1.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "tl_xbar_defs.svh"

module tl_socket_m1 (
  input  logic            clk_i,
  input  logic            reset_i,
  tl_if.device            host_if [`TL_NUM_HOSTS-1:0],
  output logic            link_a_valid_o,
  input  logic            link_a_ready_i,
  output tl_pkg::tl_a_t   link_a_o,
  input  logic            link_d_valid_i,
  output logic            link_d_ready_o,
  input  tl_pkg::tl_d_t   link_d_i
);
  import tl_pkg::*;

  localparam int N    = `TL_NUM_HOSTS;
  localparam int IdxW = $clog2(N);

  logic [N-1:0]    req;
  logic [N-1:0]    d_ready;
  tl_a_t           req_a [N-1:0];
  logic [IdxW-1:0] last_q;
  logic [IdxW-1:0] arb_sel;
  logic [IdxW-1:0] sel;
  logic [IdxW-1:0] lock_sel_q;
  logic            lock_q;
  logic [IdxW-1:0] d_host;

  // Owner of a source ID
  function automatic logic [IdxW-1:0] src_host(logic [`TL_SOURCE_WIDTH-1:0] src);
    if (src >= `TL_HOST2_SRC_BASE) return IdxW'(2);
    if (src >= `TL_HOST1_SRC_BASE) return IdxW'(1);
    return IdxW'(0);
  endfunction

  for (genvar i = 0; i < N; i++) begin : g_host
    assign req[i]             = host_if[i].a_valid;
    assign req_a[i]           = host_if[i].a;
    assign host_if[i].a_ready = link_a_ready_i && req[i] && (sel == IdxW'(i));
    assign host_if[i].d_valid = link_d_valid_i && (d_host == IdxW'(i));
    assign host_if[i].d       = link_d_i;
    assign d_ready[i]         = host_if[i].d_ready;

    a_src_range: assert property (@(posedge clk_i) disable iff (reset_i)
      host_if[i].a_valid |-> src_host(host_if[i].a.source) == IdxW'(i));
  end

  // Round robin, search starts after the last winner
  always_comb begin
    int idx;
    arb_sel = last_q;
    for (int k = N; k >= 1; k--) begin
      idx = (int'(last_q) + k) % N;
      if (req[idx]) begin
        arb_sel = IdxW'(idx);
      end
    end
  end

  assign sel            = lock_q ? lock_sel_q : arb_sel;
  assign link_a_valid_o = req[sel];
  assign link_a_o       = req_a[sel];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      last_q <= IdxW'(N - 1);
    end else begin
      lock_q <= link_a_valid_o && !link_a_ready_i;
      if (link_a_valid_o && link_a_ready_i) begin
        last_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    lock_sel_q <= sel;
  end

  // Response return path
  assign d_host         = src_host(link_d_i.source);
  assign link_d_ready_o = link_d_valid_i && d_ready[d_host];

endmodule

//--- src/tl_xbar.sv
// ----------------------------------------------------------------------
// Three hosts, three devices over one registered link. Request and
// response each take one cycle across the link when uncontested.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "tl_xbar_defs.svh"

module tl_xbar (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // Hosts
  input  logic                        host_a_valid_i   [`TL_NUM_HOSTS-1:0],
  output logic                        host_a_ready_o   [`TL_NUM_HOSTS-1:0],
  input  tl_pkg::tl_a_op_e            host_a_opcode_i  [`TL_NUM_HOSTS-1:0],
  input  logic [`TL_SIZE_WIDTH-1:0]   host_a_size_i    [`TL_NUM_HOSTS-1:0],
  input  logic [`TL_SOURCE_WIDTH-1:0] host_a_source_i  [`TL_NUM_HOSTS-1:0],
  input  logic [`TL_ADDR_WIDTH-1:0]   host_a_address_i [`TL_NUM_HOSTS-1:0],
  input  logic [`TL_DATA_WIDTH/8-1:0] host_a_mask_i    [`TL_NUM_HOSTS-1:0],
  input  logic [`TL_DATA_WIDTH-1:0]   host_a_data_i    [`TL_NUM_HOSTS-1:0],
  output logic                        host_d_valid_o   [`TL_NUM_HOSTS-1:0],
  input  logic                        host_d_ready_i   [`TL_NUM_HOSTS-1:0],
  output tl_pkg::tl_d_op_e            host_d_opcode_o  [`TL_NUM_HOSTS-1:0],
  output logic [`TL_SIZE_WIDTH-1:0]   host_d_size_o    [`TL_NUM_HOSTS-1:0],
  output logic [`TL_SOURCE_WIDTH-1:0] host_d_source_o  [`TL_NUM_HOSTS-1:0],
  output logic                        host_d_denied_o  [`TL_NUM_HOSTS-1:0],
  output logic [`TL_DATA_WIDTH-1:0]   host_d_data_o    [`TL_NUM_HOSTS-1:0],

  // Devices
  output logic                        dev_a_valid_o    [`TL_NUM_DEVICES-1:0],
  input  logic                        dev_a_ready_i    [`TL_NUM_DEVICES-1:0],
  output tl_pkg::tl_a_op_e            dev_a_opcode_o   [`TL_NUM_DEVICES-1:0],
  output logic [`TL_SIZE_WIDTH-1:0]   dev_a_size_o     [`TL_NUM_DEVICES-1:0],
  output logic [`TL_SOURCE_WIDTH-1:0] dev_a_source_o   [`TL_NUM_DEVICES-1:0],
  output logic [`TL_ADDR_WIDTH-1:0]   dev_a_address_o  [`TL_NUM_DEVICES-1:0],
  output logic [`TL_DATA_WIDTH/8-1:0] dev_a_mask_o     [`TL_NUM_DEVICES-1:0],
  output logic [`TL_DATA_WIDTH-1:0]   dev_a_data_o     [`TL_NUM_DEVICES-1:0],
  input  logic                        dev_d_valid_i    [`TL_NUM_DEVICES-1:0],
  output logic                        dev_d_ready_o    [`TL_NUM_DEVICES-1:0],
  input  tl_pkg::tl_d_op_e            dev_d_opcode_i   [`TL_NUM_DEVICES-1:0],
  input  logic [`TL_SIZE_WIDTH-1:0]   dev_d_size_i     [`TL_NUM_DEVICES-1:0],
  input  logic [`TL_SOURCE_WIDTH-1:0] dev_d_source_i   [`TL_NUM_DEVICES-1:0],
  input  logic                        dev_d_denied_i   [`TL_NUM_DEVICES-1:0],
  input  logic [`TL_DATA_WIDTH-1:0]   dev_d_data_i     [`TL_NUM_DEVICES-1:0]
);
  import tl_pkg::*;

  tl_if host_if [`TL_NUM_HOSTS-1:0] ();
  tl_if dev_if [`TL_NUM_DEVICES-1:0] ();

  // Shared link, either side of the slices
  logic  m1_a_valid, m1_a_ready, n1_a_valid, n1_a_ready;
  logic  m1_d_valid, m1_d_ready, n1_d_valid, n1_d_ready;
  tl_a_t m1_a, n1_a;
  tl_d_t m1_d, n1_d;

  for (genvar i = 0; i < `TL_NUM_HOSTS; i++) begin : g_host
    assign host_if[i].a_valid = host_a_valid_i[i];
    assign host_a_ready_o[i]  = host_if[i].a_ready;
    assign host_if[i].a       = '{opcode:  host_a_opcode_i[i],
                                  size:    host_a_size_i[i],
                                  source:  host_a_source_i[i],
                                  address: host_a_address_i[i],
                                  mask:    host_a_mask_i[i],
                                  data:    host_a_data_i[i]};
    assign host_d_valid_o[i]  = host_if[i].d_valid;
    assign host_if[i].d_ready = host_d_ready_i[i];
    assign host_d_opcode_o[i] = host_if[i].d.opcode;
    assign host_d_size_o[i]   = host_if[i].d.size;
    assign host_d_source_o[i] = host_if[i].d.source;
    assign host_d_denied_o[i] = host_if[i].d.denied;
    assign host_d_data_o[i]   = host_if[i].d.data;
  end

  for (genvar i = 0; i < `TL_NUM_DEVICES; i++) begin : g_dev
    assign dev_a_valid_o[i]   = dev_if[i].a_valid;
    assign dev_if[i].a_ready  = dev_a_ready_i[i];
    assign dev_a_opcode_o[i]  = dev_if[i].a.opcode;
    assign dev_a_size_o[i]    = dev_if[i].a.size;
    assign dev_a_source_o[i]  = dev_if[i].a.source;
    assign dev_a_address_o[i] = dev_if[i].a.address;
    assign dev_a_mask_o[i]    = dev_if[i].a.mask;
    assign dev_a_data_o[i]    = dev_if[i].a.data;
    assign dev_if[i].d_valid  = dev_d_valid_i[i];
    assign dev_d_ready_o[i]   = dev_if[i].d_ready;
    assign dev_if[i].d        = '{opcode: dev_d_opcode_i[i],
                                  size:   dev_d_size_i[i],
                                  source: dev_d_source_i[i],
                                  denied: dev_d_denied_i[i],
                                  data:   dev_d_data_i[i]};
  end

  tl_socket_m1 u_socket_m1 (
    .clk_i,
    .reset_i,
    .host_if        (host_if),
    .link_a_valid_o (m1_a_valid),
    .link_a_ready_i (m1_a_ready),
    .link_a_o       (m1_a),
    .link_d_valid_i (m1_d_valid),
    .link_d_ready_o (m1_d_ready),
    .link_d_i       (m1_d)
  );

  tl_reg_slice #(.payload_t(tl_a_t)) u_a_slice (
    .clk_i,
    .reset_i,
    .in_valid_i  (m1_a_valid),
    .in_ready_o  (m1_a_ready),
    .in_data_i   (m1_a),
    .out_valid_o (n1_a_valid),
    .out_ready_i (n1_a_ready),
    .out_data_o  (n1_a)
  );

  tl_reg_slice #(.payload_t(tl_d_t)) u_d_slice (
    .clk_i,
    .reset_i,
    .in_valid_i  (n1_d_valid),
    .in_ready_o  (n1_d_ready),
    .in_data_i   (n1_d),
    .out_valid_o (m1_d_valid),
    .out_ready_i (m1_d_ready),
    .out_data_o  (m1_d)
  );

  tl_socket_1n u_socket_1n (
    .clk_i,
    .reset_i,
    .link_a_valid_i (n1_a_valid),
    .link_a_ready_o (n1_a_ready),
    .link_a_i       (n1_a),
    .link_d_valid_o (n1_d_valid),
    .link_d_ready_i (n1_d_ready),
    .link_d_o       (n1_d),
    .dev_if         (dev_if)
  );

endmodule

//--- src/tl_xbar_defs.svh
// ----------------------------------------------------------------------
// Fixed crossbar geometry and routing tables. Changing a count here
// needs matching edits to the decode functions in the two sockets.
// ----------------------------------------------------------------------
`ifndef TL_XBAR_DEFS_SVH
`define TL_XBAR_DEFS_SVH

`define TL_ADDR_WIDTH 32
`define TL_DATA_WIDTH 32
`define TL_SIZE_WIDTH 2
`define TL_SOURCE_WIDTH 3
`define TL_NUM_HOSTS 3
`define TL_NUM_DEVICES 3

// Top address nibble per device, anything else lands on device 0
`define TL_DEV1_BASE 4'h1
`define TL_DEV2_BASE 4'h2

// Source ID bases, hosts 1 and 2 own two IDs each
`define TL_HOST1_SRC_BASE 3'd4
`define TL_HOST2_SRC_BASE 3'd6

`endif
